//--- hdl/jt900h_pkg.sv
// Shared types and constants for the TLCS-900H style core slice.
// Every design file that needs a width type, an ALU code or a size
// imports this package.

package jt900h_pkg;

    typedef logic [31:0] word_t;      // data word, opcode window, register data
    typedef logic [23:0] addr_t;      // program byte address
    typedef logic [ 7:0] reg_addr_t;  // full register address, E0..FF used
    typedef logic [ 2:0] width_t;     // one-hot byte/word/long, zero = no write
    typedef logic [ 5:0] alu_op_t;

    localparam alu_op_t ALU_NOP  = 6'd0;
    localparam alu_op_t ALU_MOVE = 6'd1;
    localparam alu_op_t ALU_ADD  = 6'd2;

    // controller phases
    typedef enum logic [1:0] {
        FETCH,
        EXEC,      // second byte of the two-register prefix forms
        FILL_IMM,  // upper bytes of a wide immediate
        ILLEGAL    // stuck here until reset
    } phase_t;

    localparam int NUM_LANES = 4;  // byte lanes per long register
    localparam int NUM_REGS  = 8;  // long registers
    localparam int WIN_BYTES = 8;  // opcode window depth

endpackage

//--- hdl/jt900h_exec_if.sv
// Execution command bundle from the instruction controller.
// The controller drives all of it; the ALU and the register file each
// see only the part they act on.

`timescale 1ns/1ps

interface jt900h_exec_if;
    import jt900h_pkg::*;

    width_t    regs_we;   // write width strobe
    reg_addr_t regs_dst;
    reg_addr_t regs_src;
    alu_op_t   alu_op;
    word_t     alu_imm;
    logic      alu_smux;  // 1 = immediate operand
    logic      alu_wait;  // hold the write, immediate still filling

    modport ctrl (
        output regs_we, regs_dst, regs_src, alu_op, alu_imm, alu_smux, alu_wait
    );
    modport alu (
        input alu_op, alu_imm, alu_smux, regs_we
    );
    modport regs (
        input regs_we, regs_dst, regs_src, alu_wait
    );

endinterface

//--- hdl/jt900h_fetch.sv
// Opcode fetch unit.
// Reads 32-bit words from a synchronous program memory and keeps an
// 8-byte window of the instruction stream. op shows the four oldest
// bytes, first byte in op[7:0]. The controller reports how many bytes
// it used through fetched; those drop out at the next enabled edge.

`timescale 1ns/1ps

module jt900h_fetch(
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  jt900h_pkg::word_t rom_data,
    input  logic [1:0]        fetched,
    output jt900h_pkg::addr_t rom_addr,
    output jt900h_pkg::word_t op,
    output logic              op_ok
);
    import jt900h_pkg::*;

    logic [8*WIN_BYTES-1:0] win, nx_win;
    logic [3:0]             cnt, nx_cnt;  // valid bytes, 0..8
    logic [3:0]             used;         // bytes consumed this cycle
    logic [3:0]             left;         // bytes kept after consumption
    logic                   data_ok;      // rom_data belongs to rom_addr
    logic                   take;

    assign op    = win[31:0];
    assign op_ok = cnt >= 4'd4;

    always_comb begin
        used   = op_ok ? {2'b00, fetched} : 4'd0;
        left   = cnt - used;
        take   = data_ok && left <= 4'd4;  // room for a whole word
        nx_win = win >> {used, 3'b000};
        if (take) begin
            // new word lands right behind the kept bytes
            for (int k = 0; k < 4; k++) begin
                nx_win[8*(int'(left)+k) +: 8] = rom_data[8*k +: 8];
            end
        end
        nx_cnt = take ? left + 4'd4 : left;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt      <= 4'd0;
            data_ok  <= 1'b0;
            rom_addr <= '0;
        end else if (cen) begin
            cnt     <= nx_cnt;
            data_ok <= !take;  // one cycle of memory latency after a new address
            if (take) begin
                rom_addr <= rom_addr + 24'd4;
            end
        end
    end

    // window bytes past cnt are don't care
    always_ff @(posedge clk) begin
        if (cen) begin
            win <= nx_win;
        end
    end

endmodule

//--- hdl/jt900h_ctrl.sv
// Instruction control unit.
// Decodes the opcode window from the fetch unit and issues registered
// ALU and register-file commands, one cycle long each. It tells the
// fetch unit how many bytes it used. Supports NOP, LD R,# and the
// two-register prefix forms; anything else ends in the ILLEGAL phase.

`timescale 1ns/1ps

module jt900h_ctrl(
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  jt900h_pkg::word_t op,
    input  logic              op_ok,
    output logic [1:0]        fetched,  // bytes consumed this cycle
    output logic              illegal,
    jt900h_exec_if.ctrl       exec
);
    import jt900h_pkg::*;

    phase_t    op_phase, nx_phase;
    logic [1:0] op_zz, nx_op_zz;     // operand size, 0 byte 1 word 2 long
    logic      ram_wait, nx_ram_wait;
    width_t    nx_regs_we;
    reg_addr_t nx_src, nx_dst;
    alu_op_t   nx_alu_op;
    word_t     nx_alu_imm;
    logic      nx_alu_smux, nx_alu_wait;

    function automatic width_t expand_zz(input logic [1:0] zz);
        return zz == 2'd0 ? 3'b001 : zz == 2'd1 ? 3'b010 : 3'b100;
    endfunction

    // short 3-bit register code to full address
    function automatic reg_addr_t expand_reg(input logic [2:0] short_reg,
                                             input logic [1:0] zz);
        if (zz == 2'd0)
            return {4'he, short_reg[2:1], 1'b0, ~short_reg[0]};
        else
            return {3'b111, short_reg[2], short_reg[1:0], 2'd0};
    endfunction

    assign illegal = op_phase == ILLEGAL;

    always_comb begin
        fetched     = 2'd0;
        nx_phase    = op_phase;
        nx_op_zz    = op_zz;
        nx_src      = exec.regs_src;
        nx_dst      = exec.regs_dst;
        nx_alu_op   = exec.alu_op;
        nx_alu_imm  = exec.alu_imm;
        nx_alu_smux = exec.alu_smux;
        nx_alu_wait = 1'b0;
        nx_regs_we  = '0;  // write strobe lasts one cycle
        if (op_ok && !ram_wait) begin
            case (op_phase)
                FETCH: begin
                    casez (op[7:0])
                        8'h00: fetched = 2'd1;  // NOP
                        8'b1100_1???, 8'b1101_1???, 8'b1110_1???: begin
                            nx_op_zz = op[5:4];  // prefix, r part
                            nx_dst   = expand_reg(op[2:0], op[5:4]);
                            nx_phase = EXEC;
                            fetched  = 2'd1;
                        end
                        8'b0010_0???, 8'b0011_0???, 8'b0100_0???: begin  // LD R,#
                            nx_op_zz    = op[6:4] == 3'd2 ? 2'd0 :
                                          op[6:4] == 3'd3 ? 2'd1 : 2'd2;
                            nx_dst      = expand_reg(op[2:0], nx_op_zz);
                            nx_alu_imm  = {24'd0, op[15:8]};
                            nx_alu_op   = ALU_MOVE;
                            nx_alu_smux = 1'b1;
                            nx_regs_we  = expand_zz(nx_op_zz);
                            fetched     = 2'd2;
                            if (nx_op_zz != 2'd0) begin
                                nx_phase    = FILL_IMM;
                                nx_alu_wait = 1'b1;
                            end
                        end
                        default: nx_phase = ILLEGAL;
                    endcase
                end
                EXEC: begin
                    nx_phase    = FETCH;
                    nx_alu_smux = 1'b0;
                    nx_regs_we  = expand_zz(op_zz);
                    fetched     = 2'd1;
                    casez (op[7:0])
                        8'b1000_0???: begin  // ADD R,r
                            nx_src    = exec.regs_dst;
                            nx_dst    = expand_reg(op[2:0], op_zz);
                            nx_alu_op = ALU_ADD;
                        end
                        8'b1000_1???: begin  // LD R,r
                            nx_src    = exec.regs_dst;
                            nx_dst    = expand_reg(op[2:0], op_zz);
                            nx_alu_op = ALU_MOVE;
                        end
                        8'b1001_1???: begin  // LD r,R
                            nx_src    = expand_reg(op[2:0], op_zz);
                            nx_alu_op = ALU_MOVE;
                        end
                        8'b1010_1???: begin  // LD r,#3
                            nx_alu_imm  = {29'd0, op[2:0]};
                            nx_alu_op   = ALU_MOVE;
                            nx_alu_smux = 1'b1;
                        end
                        8'h03: begin  // LD r,#
                            nx_alu_op   = ALU_MOVE;
                            nx_alu_smux = 1'b1;
                            fetched     = 2'd2;
                            nx_alu_imm  = {24'd0, op[15:8]};
                            if (op_zz != 2'd0) begin
                                nx_alu_wait = 1'b1;
                                nx_phase    = FILL_IMM;
                            end
                        end
                        default: begin
                            nx_phase   = ILLEGAL;
                            nx_regs_we = '0;
                            fetched    = 2'd0;
                        end
                    endcase
                end
                FILL_IMM: begin
                    nx_phase   = FETCH;
                    nx_regs_we = expand_zz(op_zz);  // the held write goes out now
                    if (op_zz == 2'd1) begin
                        nx_alu_imm[31:8] = {16'd0, op[7:0]};
                        fetched = 2'd1;
                    end else begin
                        nx_alu_imm[31:8] = op[23:0];
                        fetched = 2'd3;
                    end
                end
                default: nx_phase = ILLEGAL;
            endcase
        end
        nx_ram_wait = fetched != 2'd0;  // let the window settle
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            op_phase      <= FETCH;
            op_zz         <= 2'd0;
            ram_wait      <= 1'b0;
            exec.regs_we  <= '0;
            exec.regs_src <= '0;
            exec.regs_dst <= '0;
            exec.alu_op   <= ALU_NOP;
            exec.alu_imm  <= '0;
            exec.alu_smux <= 1'b0;
            exec.alu_wait <= 1'b0;
        end else if (cen) begin
            op_phase      <= nx_phase;
            op_zz         <= nx_op_zz;
            ram_wait      <= nx_ram_wait;
            exec.regs_we  <= nx_regs_we;
            exec.regs_src <= nx_src;
            exec.regs_dst <= nx_dst;
            exec.alu_op   <= nx_alu_op;
            exec.alu_imm  <= nx_alu_imm;
            exec.alu_smux <= nx_alu_smux;
            exec.alu_wait <= nx_alu_wait;
        end
    end

endmodule

//--- hdl/jt900h_alu.sv
// ALU for the core slice: move and add at byte, word or long width.
// The result is truncated to the write width; carry and zero are
// updated only by an ADD that writes back.

`timescale 1ns/1ps

module jt900h_alu(
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  jt900h_pkg::word_t src_data,
    input  jt900h_pkg::word_t dst_data,
    output jt900h_pkg::word_t result,
    output logic              flag_c,
    output logic              flag_z,
    jt900h_exec_if.alu        exec
);
    import jt900h_pkg::*;

    word_t       mask;
    logic [32:0] sum;
    logic        carry;

    always_comb begin
        case (exec.regs_we)
            3'b001:  mask = 32'h0000_00ff;
            3'b010:  mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
        sum = {1'b0, dst_data & mask} + {1'b0, src_data & mask};
        case (exec.regs_we)
            3'b001:  carry = sum[8];
            3'b010:  carry = sum[16];
            default: carry = sum[32];
        endcase
        case (exec.alu_op)
            ALU_MOVE: result = (exec.alu_smux ? exec.alu_imm : src_data) & mask;
            ALU_ADD:  result = sum[31:0] & mask;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            flag_c <= 1'b0;
            flag_z <= 1'b0;
        end else if (cen && exec.alu_op == ALU_ADD && exec.regs_we != '0) begin
            flag_c <= carry;
            flag_z <= result == '0;
        end
    end

endmodule

//--- hdl/jt900h_reg_lane.sv
// One byte lane of the register file.
// Holds this lane's byte of all eight long registers, with one write
// port and separate source and destination read ports.

`timescale 1ns/1ps

module jt900h_reg_lane(
    input  logic       clk,
    input  logic       rst,
    input  logic       lane_we,
    input  logic [2:0] wr_reg,
    input  logic [7:0] wr_byte,
    input  logic [2:0] rd_src,
    input  logic [2:0] rd_dst,
    output logic [7:0] src_byte,
    output logic [7:0] dst_byte
);
    import jt900h_pkg::*;

    logic [7:0] mem [NUM_REGS];

    assign src_byte = mem[rd_src];
    assign dst_byte = mem[rd_dst];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                mem[i] <= 8'd0;
            end
        end else if (lane_we) begin
            mem[wr_reg] <= wr_byte;  // cen already folded into lane_we
        end
    end

endmodule

//--- hdl/jt900h_regs.sv
// Register file built from four byte lanes.
// Aligns the ALU result to the destination byte offset, enables the
// lanes covered by the write width, and assembles the source and
// destination read words shifted down to their byte offsets.
// The wb_* ports expose the write as it happens.

`timescale 1ns/1ps

module jt900h_regs(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  jt900h_pkg::word_t     result,
    output jt900h_pkg::word_t     src_data,
    output jt900h_pkg::word_t     dst_data,
    output jt900h_pkg::width_t    wb_we,
    output jt900h_pkg::reg_addr_t wb_reg,
    output jt900h_pkg::word_t     wb_data,
    jt900h_exec_if.regs           exec
);
    import jt900h_pkg::*;

    width_t               wr_we;
    logic [1:0]           wr_off;
    logic [1:0]           wr_off_hi;  // second lane of a word write
    word_t                wr_aligned;
    logic [NUM_LANES-1:0] lane_we;
    word_t                src_full, dst_full;

    assign wr_we      = (cen && !exec.alu_wait) ? exec.regs_we : '0;
    assign wr_off     = exec.regs_dst[1:0];
    assign wr_off_hi  = wr_off + 2'd1;
    assign wr_aligned = result << {wr_off, 3'b000};

    always_comb begin
        lane_we = '0;
        case (wr_we)
            3'b001: lane_we[wr_off] = 1'b1;
            3'b010: begin
                lane_we[wr_off]    = 1'b1;
                lane_we[wr_off_hi] = 1'b1;
            end
            3'b100: lane_we = '1;
            default:;
        endcase
    end

    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_lane
            jt900h_reg_lane lane_i(
                .clk      (clk),
                .rst      (rst),
                .lane_we  (lane_we[i]),
                .wr_reg   (exec.regs_dst[4:2]),
                .wr_byte  (wr_aligned[8*i +: 8]),
                .rd_src   (exec.regs_src[4:2]),
                .rd_dst   (exec.regs_dst[4:2]),
                .src_byte (src_full[8*i +: 8]),
                .dst_byte (dst_full[8*i +: 8])
            );
        end
    endgenerate

    assign src_data = src_full >> {exec.regs_src[1:0], 3'b000};
    assign dst_data = dst_full >> {exec.regs_dst[1:0], 3'b000};

    // write trace
    assign wb_we   = wr_we;
    assign wb_reg  = exec.regs_dst;
    assign wb_data = result;

endmodule

//--- hdl/jt900h_core.sv
// Top level of the core slice.
// Connects the opcode fetch unit, the instruction controller, the ALU
// and the register file. The register write-back and the flags are
// brought out for observation.

`timescale 1ns/1ps

module jt900h_core(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  jt900h_pkg::word_t     rom_data,
    output jt900h_pkg::addr_t     rom_addr,
    output jt900h_pkg::width_t    wb_we,
    output jt900h_pkg::reg_addr_t wb_reg,
    output jt900h_pkg::word_t     wb_data,
    output logic                  flag_c,
    output logic                  flag_z,
    output logic                  illegal
);
    import jt900h_pkg::*;

    word_t      op;
    logic       op_ok;
    logic [1:0] fetched;
    word_t      src_data, dst_data, result;

    jt900h_exec_if exec_bus();

    jt900h_fetch fetch_i(
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rom_data (rom_data),
        .fetched  (fetched),
        .rom_addr (rom_addr),
        .op       (op),
        .op_ok    (op_ok)
    );

    jt900h_ctrl ctrl_i(
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (op),
        .op_ok    (op_ok),
        .fetched  (fetched),
        .illegal  (illegal),
        .exec     (exec_bus)
    );

    jt900h_alu alu_i(
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .src_data (src_data),
        .dst_data (dst_data),
        .result   (result),
        .flag_c   (flag_c),
        .flag_z   (flag_z),
        .exec     (exec_bus)
    );

    jt900h_regs regs_i(
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .result   (result),
        .src_data (src_data),
        .dst_data (dst_data),
        .wb_we    (wb_we),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .exec     (exec_bus)
    );

endmodule

//--- tests/jt900h_clk_gen.sv
// Testbench clock and reset source.
// 40 ns clock; rst starts high and drops on a falling edge after ten
// rising edges.

`timescale 1ns/1ps

module jt900h_clk_gen(
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD = 20;
    localparam int RST_CYCLES  = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released away from the sampling edge
    end

endmodule

//--- tests/jt900h_assertions.sv
// Concurrent checks on the core's write-back port, flags, program
// address and illegal output. Bound into jt900h_core by the testbench;
// the expected write comes from the front of the testbench's queue.

`timescale 1ns/1ps

module jt900h_assertions(
    input logic                  clk,
    input logic                  rst,
    input logic                  cen,
    input jt900h_pkg::addr_t     rom_addr,
    input jt900h_pkg::width_t    wb_we,
    input jt900h_pkg::reg_addr_t wb_reg,
    input jt900h_pkg::word_t     wb_data,
    input logic                  flag_c,
    input logic                  flag_z,
    input logic                  illegal
);
    int unsigned fail_count = 0;

    reset_state: assert property (@(posedge clk)
        (rst || $fell(rst)) |->
        (wb_we == '0 && !illegal && !flag_c && !flag_z && rom_addr == '0))
    else begin
        fail_count++;
        $error("outputs not in their reset state during or right after reset");
    end

    write_expected: assert property (@(posedge clk) disable iff (rst)
        (wb_we != '0) |-> jt900h_tb.exp_valid)
    else begin
        fail_count++;
        $error("register write-back with no expected write pending");
    end

    write_width: assert property (@(posedge clk) disable iff (rst)
        (wb_we != '0 && jt900h_tb.exp_valid) |-> (wb_we == jt900h_tb.exp_we))
    else begin
        fail_count++;
        $error("MISMATCH wb_we: got %h, expected %h", $sampled(wb_we),
               $sampled(jt900h_tb.exp_we));
    end

    write_reg: assert property (@(posedge clk) disable iff (rst)
        (wb_we != '0 && jt900h_tb.exp_valid) |-> (wb_reg == jt900h_tb.exp_reg))
    else begin
        fail_count++;
        $error("MISMATCH wb_reg: got %h, expected %h", $sampled(wb_reg),
               $sampled(jt900h_tb.exp_reg));
    end

    write_data: assert property (@(posedge clk) disable iff (rst)
        (wb_we != '0 && jt900h_tb.exp_valid) |-> (wb_data == jt900h_tb.exp_data))
    else begin
        fail_count++;
        $error("MISMATCH wb_data: got %h, expected %h", $sampled(wb_data),
               $sampled(jt900h_tb.exp_data));
    end

    // flags settle one edge after the ADD write
    add_flags: assert property (@(posedge clk) disable iff (rst)
        (wb_we != '0 && jt900h_tb.exp_valid && jt900h_tb.exp_add) |=>
        (flag_c == jt900h_tb.last_c && flag_z == jt900h_tb.last_z))
    else begin
        fail_count++;
        $error("MISMATCH flag_c/flag_z: got %h/%h, expected %h/%h",
               $sampled(flag_c), $sampled(flag_z),
               $sampled(jt900h_tb.last_c), $sampled(jt900h_tb.last_z));
    end

    // program memory is read one word after the other
    rom_step: assert property (@(posedge clk) disable iff (rst)
        (rom_addr != $past(rom_addr)) |-> (rom_addr == $past(rom_addr) + 24'd4))
    else begin
        fail_count++;
        $error("rom_addr did not advance by exactly one word");
    end

    cen_low_holds: assert property (@(posedge clk) disable iff (rst)
        !cen |=> ($stable(rom_addr) && $stable(flag_c) && $stable(flag_z)
                  && $stable(illegal)))
    else begin
        fail_count++;
        $error("core state changed on an edge with cen low");
    end

    illegal_stops_writes: assert property (@(posedge clk) disable iff (rst)
        illegal |-> (wb_we == '0))
    else begin
        fail_count++;
        $error("register write-back after an illegal opcode");
    end

    illegal_sticky: assert property (@(posedge clk) disable iff (rst)
        illegal |=> illegal)
    else begin
        fail_count++;
        $error("illegal dropped before reset");
    end

    illegal_last: assert property (@(posedge clk) disable iff (rst)
        $rose(illegal) |-> !jt900h_tb.exp_valid)
    else begin
        fail_count++;
        $error("illegal raised while expected writes were still pending");
    end

endmodule

//--- tests/jt900h_tb.sv
// Testbench for the core slice.
// Builds a random program of NOP, LD R,# and two-register prefix
// instructions in a ROM model, predicts every register write-back from
// a shadow copy of the registers and ends the program on an illegal
// opcode. The bound checker compares the DUT with the expected writes.

`timescale 1ns/1ps

module jt900h_tb;
    import jt900h_pkg::*;

    localparam int ROM_BYTES  = 1024;
    localparam int NUM_INSTR  = 80;
    localparam int WAIT_LIMIT = 5000;  // cycles per wait loop

    typedef struct packed {
        width_t    we;
        reg_addr_t rg;
        word_t     data;
        logic      add;  // flags follow this write
        logic      c;
        logic      z;
    } wb_t;

    logic      clk, rst;
    logic      cen = 1'b0;
    word_t     rom_data = '0;
    addr_t     rom_addr;
    width_t    wb_we;
    reg_addr_t wb_reg;
    word_t     wb_data;
    logic      flag_c, flag_z, illegal;

    logic [7:0] rom [ROM_BYTES];
    word_t      shadow [NUM_REGS];
    int         pc;
    wb_t        exp_q [$];

    // queue front as seen by the checker, updated on falling edges
    logic      exp_valid = 1'b0;
    width_t    exp_we = '0;
    reg_addr_t exp_reg = '0;
    word_t     exp_data = '0;
    logic      exp_add = 1'b0;
    logic      last_c = 1'b0;  // flags of the write just retired
    logic      last_z = 1'b0;
    logic      wrote = 1'b0;
    int        cen_hold = 0;
    int        timeouts = 0;

    jt900h_clk_gen clk_gen_i(
        .clk (clk),
        .rst (rst)
    );

    jt900h_core dut_i(
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rom_data (rom_data),
        .rom_addr (rom_addr),
        .wb_we    (wb_we),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .flag_c   (flag_c),
        .flag_z   (flag_z),
        .illegal  (illegal)
    );

    bind jt900h_core jt900h_assertions chk_i(
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rom_addr (rom_addr),
        .wb_we    (wb_we),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .flag_c   (flag_c),
        .flag_z   (flag_z),
        .illegal  (illegal)
    );

    // byte codes W,A,B,C,D,E,H,L live in bytes 1 and 0 of XWA..XHL
    function automatic reg_addr_t reg_code(input logic [2:0] r, input logic [1:0] zz);
        if (zz == 2'd0)
            return 8'(8'he0 + 4 * (r / 2) + (r[0] ? 0 : 1));
        return 8'(8'he0 + 4 * r);
    endfunction

    function automatic word_t width_mask(input logic [1:0] zz);
        return zz == 2'd0 ? 32'h0000_00ff : zz == 2'd1 ? 32'h0000_ffff : 32'hffff_ffff;
    endfunction

    function automatic word_t read_reg(input reg_addr_t a, input logic [1:0] zz);
        return (shadow[a[4:2]] >> (8 * a[1:0])) & width_mask(zz);
    endfunction

    function automatic word_t rom_word(input addr_t a);
        int base;
        base = int'(a) % ROM_BYTES;
        return {rom[base+3], rom[base+2], rom[base+1], rom[base]};
    endfunction

    task automatic put_byte(input logic [7:0] b);
        rom[pc] = b;
        pc++;
    endtask

    task automatic expect_write(input reg_addr_t a, input logic [1:0] zz, input word_t v,
                                input logic add, input logic c);
        wb_t   e;
        word_t m;
        e.we   = width_t'(3'b001 << zz);
        e.rg   = a;
        e.data = v & width_mask(zz);
        e.add  = add;
        e.c    = c;
        e.z    = e.data == '0;
        exp_q.push_back(e);
        m = width_mask(zz) << (8 * a[1:0]);
        shadow[a[4:2]] = (shadow[a[4:2]] & ~m) | ((e.data << (8 * a[1:0])) & m);
    endtask

    task automatic gen_instr();
        logic [1:0]  zz;
        logic [2:0]  r, rr;
        word_t       imm;
        logic [32:0] sum;
        reg_addr_t   src, dst;
        zz  = 2'($urandom % 3);
        r   = 3'($urandom);
        rr  = 3'($urandom);
        imm = $urandom;
        src = reg_code(r, zz);
        dst = reg_code(rr, zz);
        case ($urandom % 6)
            0: put_byte(8'h00);  // NOP
            1, 2: begin  // LD R,# with 1, 2 or 4 immediate bytes
                put_byte(8'h20 + {2'b00, zz, 4'h0} + {5'd0, r});
                for (int i = 0; i < (1 << zz); i++) begin
                    put_byte(imm[8*i +: 8]);
                end
                expect_write(src, zz, imm, 1'b0, 1'b0);
            end
            default: begin
                put_byte({2'b11, zz, 1'b1, r});  // prefix selects r and size
                case ($urandom % 4)
                    0: begin  // ADD R,r
                        put_byte({5'b10000, rr});
                        sum = {1'b0, read_reg(dst, zz)} + {1'b0, read_reg(src, zz)};
                        expect_write(dst, zz, sum[31:0], 1'b1, sum[8 << zz]);
                    end
                    1: begin  // LD R,r
                        put_byte({5'b10001, rr});
                        expect_write(dst, zz, read_reg(src, zz), 1'b0, 1'b0);
                    end
                    2: begin  // LD r,R
                        put_byte({5'b10011, rr});
                        expect_write(src, zz, read_reg(dst, zz), 1'b0, 1'b0);
                    end
                    default: begin  // LD r,#3
                        put_byte({5'b10101, rr});
                        expect_write(src, zz, word_t'(rr), 1'b0, 1'b0);
                    end
                endcase
            end
        endcase
    endtask

    task automatic build_program();
        for (int a = 0; a < ROM_BYTES; a++) begin
            rom[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;  // filler past the program end
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        pc = 0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            gen_instr();
        end
        put_byte(8'hff);  // no such opcode
    endtask

    // synchronous ROM and clock enable, both on the falling edge
    always @(negedge clk) begin
        rom_data <= rom_word(rom_addr);
        if (cen_hold > 0) begin
            cen_hold--;
            cen <= 1'b0;
        end else if ($urandom % 6 == 0) begin
            cen_hold = int'($urandom % 4);
            cen <= 1'b0;
        end else begin
            cen <= 1'b1;
        end
    end

    always @(posedge clk) begin
        wrote <= wb_we != '0;
    end

    // retire the write seen on the last rising edge
    always @(negedge clk) begin
        if (wrote && exp_q.size() > 0) begin
            last_c = exp_q[0].c;
            last_z = exp_q[0].z;
            void'(exp_q.pop_front());
        end
        exp_valid = exp_q.size() > 0;
        if (exp_valid) begin
            exp_we   = exp_q[0].we;
            exp_reg  = exp_q[0].rg;
            exp_data = exp_q[0].data;
            exp_add  = exp_q[0].add;
        end
    end

    initial begin
        int cycles;
        void'($urandom(42714));
        build_program();
        cycles = 0;
        while (rst && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("timeout: %0d expected writes never happened", exp_q.size());
        end
        cycles = 0;
        while (!illegal && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!illegal) begin
            timeouts++;
            $display("timeout: illegal never rose after the last instruction");
        end
        repeat (10) @(negedge clk);  // stray writes after illegal would fire here
        $display("errors: %0d assertion failures, %0d timeouts",
                 dut_i.chk_i.fail_count, timeouts);
        if (dut_i.chk_i.fail_count == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/jt900h_pkg.sv
hdl/jt900h_exec_if.sv
hdl/jt900h_fetch.sv
hdl/jt900h_ctrl.sv
hdl/jt900h_alu.sv
hdl/jt900h_reg_lane.sv
hdl/jt900h_regs.sv
hdl/jt900h_core.sv
tests/jt900h_clk_gen.sv
tests/jt900h_assertions.sv
tests/jt900h_tb.sv

//--- Makefile
VERILATOR   := verilator
TOP         := jt900h_tb
FILELIST    := vlog.f
OBJ_DIR     := obj_dir
BUILD_FLAGS := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only -Wall --timing --assert --top-module $(TOP)
RUN_ARGS    := +verilator+error+limit+1000
PASS_MSG    := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
